/* all.f */
verilog/snd_pkg.sv
verilog/snd_regs.sv
verilog/square_voice.sv
verilog/snd_mixer.sv
verilog/snd_top.sv
dv/snd_tb.sv

/* dv/snd_tb.sv */
`default_nettype none

module snd_tb import snd_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic             clk;
	logic             reset;
	logic [ADR_W-1:0] adr;
	logic [7:0]       din;
	logic [7:0]       dout;
	logic             read;
	logic             write;
	logic [15:0]      div;
	mix_t             so1_level;
	mix_t             so2_level;

	int          checks;
	int          errors;
	logic [31:0] rnd;

	snd_top uut (
		.clk       (clk),
		.reset     (reset),
		.adr       (adr),
		.din       (din),
		.dout      (dout),
		.read      (read),
		.write     (write),
		.div       (div),
		.so1_level (so1_level),
		.so2_level (so2_level)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// voice level is mid when off and swings by half the volume otherwise
	function automatic int voice_level(input logic ena, input logic high, input int vol);
		if (!ena)
			return 8;
		if (high)
			return 8 + vol / 2;
		return 8 - (vol + 1) / 2;
	endfunction

	// first duty step with the pulse high
	function automatic int first_high_step(input int duty);
		case (duty)
			0: return 1;
			1: return 2;
			2: return 4;
			default: return 6;
		endcase
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input mix_t got, input int exp);
		checks++;
		if (got !== mix_t'(exp)) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, mix_t'(exp));
		end
	endtask

	task automatic settle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic bus_write(input logic [ADR_W-1:0] a, input logic [7:0] d);
		@(posedge clk);
		adr   <= a;
		din   <= d;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		// applied on this edge while adr and din are still held
		@(posedge clk);
	endtask

	task automatic bus_read(input logic [ADR_W-1:0] a, output logic [7:0] d);
		@(posedge clk);
		adr  <= a;
		read <= 1'b1;
		@(posedge clk);
		read <= 1'b0;
		@(negedge clk);
		d = dout;
	endtask

	task automatic read_expect(input string name, input logic [ADR_W-1:0] a,
			input logic [7:0] exp);
		logic [7:0] d;
		bus_read(a, d);
		check_byte(name, d, exp);
	endtask

	// one cycle with div[1:0] at zero
	task automatic freq_tick();
		@(posedge clk);
		div <= 16'h0000;
		@(posedge clk);
		div <= 16'h0001;
		settle();
	endtask

	// falling edge of div bit 12 with the given frame step
	task automatic frame_tick(input logic [2:0] step);
		@(posedge clk);
		div <= 16'h1001;
		@(posedge clk);
		div <= {step, 13'h0001};
		@(posedge clk);
		div <= 16'h0001;
		settle();
	endtask

	task automatic start_voice(input logic second, input logic [7:0] nrx1,
			input logic [7:0] nrx2, input logic cntlen);
		logic [ADR_W-1:0] base;
		base = second ? ADR_NR21 : ADR_NR11;
		bus_write(base, nrx1);
		bus_write(base + 6'd1, nrx2);
		bus_write(base + 6'd2, 8'hff);
		// freq 2047 with the trigger bit set
		bus_write(base + 6'd3, {1'b1, cntlen, 6'h07});
	endtask

	task automatic wait_ena(input logic [1:0] mask);
		logic [7:0] st;
		logic       seen;
		seen = 1'b0;
		for (int i = 0; i < 40 && !seen; i++) begin
			bus_read(ADR_NR52, st);
			if ((st[1:0] & mask) == mask)
				seen = 1'b1;
		end
		checks++;
		if (!seen) begin
			errors++;
			$display("timeout: voice enable bits %b never came up in NR52", mask);
		end
		settle();
	endtask

	task automatic report(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	task automatic test_reset_master();
		int e0;
		e0 = errors;
		check_level("so1_level", so1_level, 16);
		check_level("so2_level", so2_level, 16);
		// dropped while powered down
		bus_write(ADR_NR12, 8'hf3);
		read_expect("NR12", ADR_NR12, 8'h00);
		read_expect("NR52", ADR_NR52, 8'h70);
		bus_write(ADR_NR52, 8'h80);
		read_expect("NR52", ADR_NR52, 8'hf0);
		report("reset_master", e0);
	endtask

	task automatic test_readback();
		int         e0;
		logic [7:0] d;
		e0 = errors;
		d = rand_byte();
		bus_write(ADR_NR11, d);
		read_expect("NR11", ADR_NR11, {d[7:6], 6'h3f});
		d = rand_byte();
		bus_write(ADR_NR12, d);
		read_expect("NR12", ADR_NR12, d);
		bus_write(ADR_NR13, rand_byte());
		read_expect("NR13", ADR_NR13, 8'hff);
		// keep bit 7 clear so nothing triggers
		d = rand_byte() & 8'h7f;
		bus_write(ADR_NR14, d);
		read_expect("NR14", ADR_NR14, {1'b1, d[6], 6'h3f});
		d = rand_byte();
		bus_write(ADR_NR21, d);
		read_expect("NR21", ADR_NR21, {d[7:6], 6'h3f});
		d = rand_byte();
		bus_write(ADR_NR22, d);
		read_expect("NR22", ADR_NR22, d);
		bus_write(ADR_NR23, rand_byte());
		read_expect("NR23", ADR_NR23, 8'hff);
		d = rand_byte();
		bus_write(ADR_NR50, d);
		read_expect("NR50", ADR_NR50, d);
		d = rand_byte();
		bus_write(ADR_NR51, d);
		read_expect("NR51", ADR_NR51, {2'b11, d[5:4], 2'b11, d[1:0]});
		read_expect("unmapped", 6'h20, 8'hff);
		report("readback", e0);
	endtask

	task automatic test_duty();
		int e0;
		int first;
		int high_cnt;
		e0 = errors;
		bus_write(ADR_NR51, 8'h01);
		for (int duty = 0; duty < 4; duty++) begin
			first = first_high_step(duty);
			high_cnt = 0;
			start_voice(1'b0, {duty[1:0], 6'h00}, 8'hf0, 1'b0);
			wait_ena(2'b01);
			for (int s = 0; s < 8; s++) begin
				check_level("so1_level", so1_level, voice_level(1'b1, s >= first, 15) + 8);
				check_level("so2_level", so2_level, 16);
				if (so1_level == 5'd23)
					high_cnt++;
				freq_tick();
			end
			checks++;
			if (high_cnt != 8 - first) begin
				errors++;
				$display("MISMATCH high_steps: got %h, expected %h", high_cnt, 8 - first);
			end
		end
		report("duty", e0);
	endtask

	task automatic test_length();
		int         e0;
		int         ticks;
		logic [5:0] len;
		logic [7:0] st;
		e0 = errors;
		rnd = $urandom;
		len = rnd[5:0];
		start_voice(1'b0, {2'b10, len}, 8'hf0, 1'b1);
		wait_ena(2'b01);
		ticks = 64 - int'(len);
		for (int i = 0; i < ticks; i++)
			frame_tick(3'd0);
		bus_read(ADR_NR52, st);
		check_byte("NR52 bit 0", st & 8'h01, 8'h01);
		// one past the limit
		frame_tick(3'd0);
		bus_read(ADR_NR52, st);
		check_byte("NR52 bit 0", st & 8'h01, 8'h00);
		check_level("so1_level", so1_level, 16);
		report("length", e0);
	endtask

	task automatic test_envelope();
		int e0;
		int vol;
		e0 = errors;
		start_voice(1'b0, 8'h00, 8'h41, 1'b0);
		wait_ena(2'b01);
		vol = 4;
		check_level("so1_level", so1_level, voice_level(1'b1, 1'b0, vol) + 8);
		for (int k = 1; k <= 10; k++) begin
			frame_tick(3'd7);
			if (k % 2 == 0 && vol > 0)
				vol--;
			check_level("so1_level", so1_level, voice_level(1'b1, 1'b0, vol) + 8);
		end
		report("envelope", e0);
	endtask

	task automatic test_mixing();
		int     e0;
		int     sum;
		level_t v1_vol;
		level_t v2_vol;
		e0 = errors;
		rnd = $urandom;
		v1_vol = rnd[3:0];
		v2_vol = rnd[7:4];
		if (v2_vol == v1_vol)
			v2_vol = v1_vol ^ 4'h5;
		bus_write(ADR_NR51, 8'h33);
		start_voice(1'b0, 8'h00, {v1_vol, 4'h0}, 1'b0);
		start_voice(1'b1, 8'h00, {v2_vol, 4'h0}, 1'b0);
		wait_ena(2'b11);
		// both at duty step 0 with the pulse low
		sum = voice_level(1'b1, 1'b0, int'(v1_vol)) + voice_level(1'b1, 1'b0, int'(v2_vol));
		check_level("so1_level", so1_level, sum);
		check_level("so2_level", so2_level, sum);
		freq_tick();
		sum = voice_level(1'b1, 1'b1, int'(v1_vol)) + voice_level(1'b1, 1'b1, int'(v2_vol));
		check_level("so1_level", so1_level, sum);
		check_level("so2_level", so2_level, sum);
		bus_write(ADR_NR52, 8'h00);
		settle();
		check_level("so1_level", so1_level, 16);
		check_level("so2_level", so2_level, 16);
		read_expect("NR52", ADR_NR52, 8'h70);
		report("mixing", e0);
	endtask

	initial begin
		rnd = $urandom(32'hac6e525a);
		checks = 0;
		errors = 0;
		reset = 1'b1;
		adr = '0;
		din = '0;
		read = 1'b0;
		write = 1'b0;
		div = 16'h0001;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		settle();

		test_reset_master();
		test_readback();
		test_duty();
		test_length();
		test_envelope();
		test_mixing();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the sound unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module snd_tb -f all.f -o snd_sim &&
./obj_dir/snd_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run ok" ||
{ echo "run failed"; exit 1; }

/* verilog/snd_mixer.sv */
`default_nettype none

module snd_mixer import snd_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire             master_ena,
	input  wire route_t     route,
	input  wire voice_out_t v1_out,
	input  wire voice_out_t v2_out,
	output mix_t            so1_level,
	output mix_t            so2_level
);

	mix_t so1_sum;
	mix_t so2_sum;

	// unrouted voice contributes the silent mid level
	function automatic mix_t pick(logic sel, level_t level);
		if (sel)
			return {1'b0, level};
		else
			return {1'b0, LEVEL_MID};
	endfunction

	always_comb begin
		so1_sum = pick(route.v1_so1, v1_out.level) + pick(route.v2_so1, v2_out.level);
		so2_sum = pick(route.v1_so2, v1_out.level) + pick(route.v2_so2, v2_out.level);
	end

	// both sides settle to idle while powered down
	always_ff @(posedge clk) begin
		if (reset || !master_ena) begin
			so1_level <= MIX_IDLE;
			so2_level <= MIX_IDLE;
		end else begin
			so1_level <= so1_sum;
			so2_level <= so2_sum;
		end
	end

	a_so1_idle: assert property (
		@(posedge clk) disable iff (reset)
		!route.v1_so1 && !route.v2_so1 |=> so1_level == MIX_IDLE
	);
	a_so2_idle: assert property (
		@(posedge clk) disable iff (reset)
		!route.v1_so2 && !route.v2_so2 |=> so2_level == MIX_IDLE
	);

endmodule

`default_nettype wire

/* verilog/snd_pkg.sv */
`default_nettype none

package snd_pkg;

	localparam int ADR_W  = 6;
	localparam int FREQ_W = 11;

	// register offsets inside the sound block
	localparam logic [ADR_W-1:0] ADR_NR11 = 6'h11;
	localparam logic [ADR_W-1:0] ADR_NR12 = 6'h12;
	localparam logic [ADR_W-1:0] ADR_NR13 = 6'h13;
	localparam logic [ADR_W-1:0] ADR_NR14 = 6'h14;
	localparam logic [ADR_W-1:0] ADR_NR21 = 6'h16;
	localparam logic [ADR_W-1:0] ADR_NR22 = 6'h17;
	localparam logic [ADR_W-1:0] ADR_NR23 = 6'h18;
	localparam logic [ADR_W-1:0] ADR_NR24 = 6'h19;
	localparam logic [ADR_W-1:0] ADR_NR50 = 6'h24;
	localparam logic [ADR_W-1:0] ADR_NR51 = 6'h25;
	localparam logic [ADR_W-1:0] ADR_NR52 = 6'h26;

	typedef logic [3:0] level_t;
	typedef logic [4:0] mix_t;

	// length counter expires one tick after reaching this
	localparam logic [6:0] LEN_LIMIT = 7'd64;

	localparam level_t LEVEL_MID = 4'd8;
	localparam mix_t   MIX_IDLE  = 5'd16;

	// first high duty step for each duty field value
	localparam logic [3:0][2:0] DUTY_THRESH = {3'd6, 3'd4, 3'd2, 3'd1};

	// per voice settings from NR11..NR14 or NR21..NR24
	typedef struct packed {
		logic [1:0]        duty;
		logic [5:0]        len;
		logic [3:0]        vol_init;
		logic              vol_inc;
		logic [2:0]        vol_time;
		logic [FREQ_W-1:0] freq;
		logic              cntlen;
	} voice_cfg_t;

	// NR51 bits of the two square voices
	typedef struct packed {
		logic v1_so1;
		logic v2_so1;
		logic v1_so2;
		logic v2_so2;
	} route_t;

	typedef struct packed {
		logic   ena;
		level_t level;
	} voice_out_t;

endpackage

`default_nettype wire

/* verilog/snd_regs.sv */
`default_nettype none

module snd_regs import snd_pkg::*; (
	input  wire              clk,
	input  wire              reset,
	input  wire [ADR_W-1:0]  adr,
	input  wire [7:0]        din,
	input  wire              read,
	input  wire              write,
	input  wire              v1_ena,
	input  wire              v2_ena,
	output logic [7:0]       dout,
	output logic             master_ena,
	output voice_cfg_t       v1_cfg,
	output voice_cfg_t       v2_cfg,
	output logic             v1_trigger,
	output logic             v2_trigger,
	output route_t           route
);

	logic             pwrite;
	logic             wr_strobe;
	logic [ADR_W-1:0] v1_off;
	logic [ADR_W-1:0] v2_off;
	logic [7:0]       nr50;
	logic [7:0]       rd_data;

	// update one voice's config from a write at offset idx (0 = NRx1)
	function automatic voice_cfg_t cfg_write(voice_cfg_t c, logic [1:0] idx, logic [7:0] d);
		voice_cfg_t r;
		r = c;
		case (idx)
			2'd0: {r.duty, r.len} = d;
			2'd1: {r.vol_init, r.vol_inc, r.vol_time} = d;
			2'd2: r.freq[7:0] = d;
			2'd3: {r.cntlen, r.freq[FREQ_W-1:8]} = {d[6], d[2:0]};
		endcase
		return r;
	endfunction

	// power off wipes everything but the length fields
	function automatic voice_cfg_t keep_len(voice_cfg_t c);
		voice_cfg_t r;
		r = '0;
		r.len = c.len;
		return r;
	endfunction

	// write lands in the cycle after the falling edge of write
	assign wr_strobe = pwrite && !write;

	assign v1_off = adr - ADR_NR11;
	assign v2_off = adr - ADR_NR21;

	always_ff @(posedge clk) begin
		pwrite     <= write;
		v1_trigger <= 1'b0;
		v2_trigger <= 1'b0;

		if (reset) begin
			pwrite     <= 1'b0;
			master_ena <= 1'b0;
			v1_cfg     <= '0;
			v2_cfg     <= '0;
			nr50       <= '0;
			route      <= '0;
		end else if (!master_ena) begin
			v1_cfg <= keep_len(v1_cfg);
			v2_cfg <= keep_len(v2_cfg);
			nr50   <= '0;
			route  <= '0;

			// only a power on through NR52 gets through
			if (wr_strobe && adr == ADR_NR52 && din[7])
				master_ena <= 1'b1;
		end else if (wr_strobe) begin
			if (v1_off[ADR_W-1:2] == '0)
				v1_cfg <= cfg_write(v1_cfg, v1_off[1:0], din);
			if (v2_off[ADR_W-1:2] == '0)
				v2_cfg <= cfg_write(v2_cfg, v2_off[1:0], din);

			v1_trigger <= adr == ADR_NR14 && din[7];
			v2_trigger <= adr == ADR_NR24 && din[7];

			case (adr)
				ADR_NR50: nr50 <= din;
				ADR_NR51: begin
					route <= '{
						v1_so1: din[0],
						v2_so1: din[1],
						v1_so2: din[4],
						v2_so2: din[5]
					};
				end
				ADR_NR52: master_ena <= din[7];
				default: ;
			endcase
		end
	end

	// write-only bits read back as ones
	always_comb begin
		case (adr)
			ADR_NR11: rd_data = {v1_cfg.duty, 6'h3f};
			ADR_NR12: rd_data = {v1_cfg.vol_init, v1_cfg.vol_inc, v1_cfg.vol_time};
			ADR_NR14: rd_data = {1'b1, v1_cfg.cntlen, 6'h3f};
			ADR_NR21: rd_data = {v2_cfg.duty, 6'h3f};
			ADR_NR22: rd_data = {v2_cfg.vol_init, v2_cfg.vol_inc, v2_cfg.vol_time};
			ADR_NR24: rd_data = {1'b1, v2_cfg.cntlen, 6'h3f};
			ADR_NR50: rd_data = nr50;
			ADR_NR51: rd_data = {2'b11, route.v2_so2, route.v1_so2, 2'b11, route.v2_so1, route.v1_so1};
			// voices 3 and 4 are not present
			ADR_NR52: rd_data = {master_ena, 3'b111, 2'b00, v2_ena, v1_ena};
			default:  rd_data = 8'hff;
		endcase
	end

	always_ff @(posedge clk) begin
		if (read)
			dout <= rd_data;
	end

	// triggers are single-cycle pulses
	a_v1_trigger_pulse: assert property (
		@(posedge clk) disable iff (reset) v1_trigger |=> !v1_trigger
	);
	a_v2_trigger_pulse: assert property (
		@(posedge clk) disable iff (reset) v2_trigger |=> !v2_trigger
	);

endmodule

`default_nettype wire

/* verilog/snd_top.sv */
`default_nettype none

module snd_top import snd_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire [ADR_W-1:0] adr,
	input  wire [7:0]       din,
	output logic [7:0]      dout,
	input  wire             read,
	input  wire             write,
	input  wire [15:0]      div,
	output mix_t            so1_level,
	output mix_t            so2_level
);

	logic       master_ena;
	voice_cfg_t v1_cfg;
	voice_cfg_t v2_cfg;
	logic       v1_trigger;
	logic       v2_trigger;
	route_t     route;
	voice_out_t v1_out;
	voice_out_t v2_out;

	snd_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.adr        (adr),
		.din        (din),
		.read       (read),
		.write      (write),
		.v1_ena     (v1_out.ena),
		.v2_ena     (v2_out.ena),
		.dout       (dout),
		.master_ena (master_ena),
		.v1_cfg     (v1_cfg),
		.v2_cfg     (v2_cfg),
		.v1_trigger (v1_trigger),
		.v2_trigger (v2_trigger),
		.route      (route)
	);

	square_voice u_voice1 (
		.clk        (clk),
		.reset      (reset),
		.div        (div),
		.master_ena (master_ena),
		.cfg        (v1_cfg),
		.trigger    (v1_trigger),
		.vout       (v1_out)
	);

	square_voice u_voice2 (
		.clk        (clk),
		.reset      (reset),
		.div        (div),
		.master_ena (master_ena),
		.cfg        (v2_cfg),
		.trigger    (v2_trigger),
		.vout       (v2_out)
	);

	snd_mixer u_mixer (
		.clk        (clk),
		.reset      (reset),
		.master_ena (master_ena),
		.route      (route),
		.v1_out     (v1_out),
		.v2_out     (v2_out),
		.so1_level  (so1_level),
		.so2_level  (so2_level)
	);

endmodule

`default_nettype wire

/* verilog/square_voice.sv */
`default_nettype none

module square_voice import snd_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire [15:0]      div,
	input  wire             master_ena,
	input  wire voice_cfg_t cfg,
	input  wire             trigger,
	output voice_out_t      vout
);

	logic              pdiv12;
	logic              freq_tick;
	logic              frame_tick;
	logic [2:0]        frame_step;
	logic              len_tick;
	logic              env_tick;

	logic              ena;
	logic [FREQ_W-1:0] freq_cnt;
	logic [2:0]        duty_step;
	logic [6:0]        len_cnt;
	logic [2:0]        env_cnt;
	level_t            vol;
	logic [4:0]        vol_up;
	logic              pulse;

	// frequency timebase runs on every fourth clock
	assign freq_tick = div[1:0] == 2'b00;

	// frame sequencer advances on the falling edge of div bit 12
	assign frame_tick = pdiv12 && !div[12];
	assign frame_step = div[15:13];

	// length on even steps and envelope on step 7 only
	assign len_tick = frame_tick && !frame_step[0];
	assign env_tick = frame_tick && frame_step == 3'd7;

	always_ff @(posedge clk) begin
		if (reset) begin
			pdiv12    <= 1'b0;
			ena       <= 1'b0;
			freq_cnt  <= '0;
			duty_step <= '0;
			len_cnt   <= '0;
			env_cnt   <= '0;
			vol       <= '0;
		end else begin
			pdiv12 <= div[12];

			if (trigger) begin
				freq_cnt  <= cfg.freq;
				duty_step <= '0;
				env_cnt   <= '0;
				len_cnt   <= {1'b0, cfg.len};
				vol       <= cfg.vol_init;
				ena       <= 1'b1;
			end else if (ena) begin
				if (freq_tick) begin
					// wrap reloads the period and moves to the next duty step
					if (&freq_cnt) begin
						freq_cnt  <= cfg.freq;
						duty_step <= duty_step + 3'd1;
					end else begin
						freq_cnt <= freq_cnt + 1'b1;
					end
				end

				if (len_tick && cfg.cntlen) begin
					if (len_cnt == LEN_LIMIT) begin
						len_cnt <= {1'b0, cfg.len};
						ena     <= 1'b0;
					end else begin
						len_cnt <= len_cnt + 7'd1;
					end
				end

				// vol_time of 0 freezes the envelope
				if (env_tick && cfg.vol_time != 3'd0) begin
					if (env_cnt == cfg.vol_time) begin
						env_cnt <= '0;
						if (cfg.vol_inc && vol != 4'hf)
							vol <= vol + 4'd1;
						else if (!cfg.vol_inc && vol != 4'h0)
							vol <= vol - 4'd1;
					end else begin
						env_cnt <= env_cnt + 3'd1;
					end
				end
			end

			if (!master_ena)
				ena <= 1'b0;
		end
	end

	// output swings around mid level and the low side rounds up
	always_comb begin
		vol_up   = {1'b0, vol} + 5'd1;
		pulse    = duty_step >= DUTY_THRESH[cfg.duty];
		vout.ena = ena;
		if (!ena)
			vout.level = LEVEL_MID;
		else if (pulse)
			vout.level = LEVEL_MID + {1'b0, vol[3:1]};
		else
			vout.level = LEVEL_MID - vol_up[4:1];
	end

	a_len_bound: assert property (
		@(posedge clk) disable iff (reset) len_cnt <= LEN_LIMIT
	);

endmodule

`default_nettype wire
